// File: Makefile
# Verilator build and run of the tcp tx queue testbench

VERILATOR ?= verilator
TOP       ?= tcp_tx_queue_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
source/tcp_txq_pkg.sv
source/tcp_byte_buffer.sv
source/tcp_segmenter.sv
source/tcp_pkt_table.sv
source/tcp_retx_scanner.sv
source/tcp_tx_queue.sv
verification/tcp_tx_queue_tb.sv

// File: source/tcp_byte_buffer.sv
// -------------------------------------------------
// tcp tx payload ring buffer
// stores user bytes, space returns as the remote acks
// -------------------------------------------------
`timescale 1ns/1ps

module tcp_byte_buffer import tcp_txq_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   sess_rst,   // reload pointers from isn
	input  logic                   w_v,
	input  logic [7:0]             w_d,
	input  logic [TXQ_DATA_AW-1:0] init_addr,
	input  logic [TXQ_DATA_AW-1:0] rd_addr,
	input  logic                   r_v,
	output logic [7:0]             r_q,
	input  logic [31:0]            rem_ack,
	output logic [TXQ_DATA_AW-1:0] space_left
);

	logic [7:0]             mem [2**TXQ_DATA_AW];
	logic [TXQ_DATA_AW-1:0] wr_ptr;   // next byte slot, tracks local seq
	logic [TXQ_DATA_AW-1:0] rel_ptr;  // first unacked byte
	logic [TXQ_DATA_AW-1:0] pend;     // bytes written but not acked
	logic                   full;
	logic                   wr_en;

	assign pend       = wr_ptr - rel_ptr;
	// one slot always kept free so pend never wraps to zero
	assign space_left = ~pend;
	assign full       = (space_left == '0);
	assign wr_en      = w_v && !full;  // bytes beyond capacity are lost

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr  <= '0;
			rel_ptr <= '0;
		end else if (sess_rst) begin
			wr_ptr  <= init_addr;
			rel_ptr <= init_addr;
		end else begin
			if (wr_en) wr_ptr <= wr_ptr + 1'b1;
			rel_ptr <= rem_ack[TXQ_DATA_AW-1:0];  // address is seq modulo ring size
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) mem[wr_ptr] <= w_d;
		if (r_v) r_q <= mem[rd_addr];  // one cycle read latency
	end

	// user must follow cts, so the ring never overflows
	a_no_write_full: assert property (@(posedge clk) disable iff (rst || sess_rst)
		w_v |-> !full);

endmodule

// File: source/tcp_pkt_table.sv
// -------------------------------------------------
// tcp tx descriptor table
// load port for new segments, update port for scanner
// -------------------------------------------------
`timescale 1ns/1ps

module tcp_pkt_table import tcp_txq_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  logic [TXQ_PKT_AW-1:0] new_addr,
	input  logic [31:0]           new_seq,
	input  logic [31:0]           new_exp_ack,
	input  logic [15:0]           new_len,
	input  logic [31:0]           new_csum,
	input  logic                  upd,
	input  logic [TXQ_PKT_AW-1:0] upd_addr,
	input  logic                  upd_present,
	input  logic [TXQ_TMR_W-1:0]  upd_timer,
	input  logic [TXQ_TRY_W-1:0]  upd_tries,
	output logic                  q_present,
	output logic [31:0]           q_seq,
	output logic [31:0]           q_exp_ack,
	output logic [15:0]           q_len,
	output logic [31:0]           q_csum,
	output logic [TXQ_TMR_W-1:0]  q_timer,
	output logic [TXQ_TRY_W-1:0]  q_tries
);

	logic                 present [2**TXQ_PKT_AW];
	logic [TXQ_TMR_W-1:0] timer   [2**TXQ_PKT_AW];
	logic [TXQ_TRY_W-1:0] tries   [2**TXQ_PKT_AW];
	logic [31:0]          seq_a   [2**TXQ_PKT_AW];
	logic [31:0]          ack_a   [2**TXQ_PKT_AW];
	logic [15:0]          len_a   [2**TXQ_PKT_AW];
	logic [31:0]          csum_a  [2**TXQ_PKT_AW];

	// status fields, written by both ports
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 2**TXQ_PKT_AW; i++) begin
				present[i] <= 1'b0;
				timer[i]   <= '0;
				tries[i]   <= '0;
			end
			q_present <= 1'b0;
			q_timer   <= '0;
			q_tries   <= '0;
		end else begin
			if (load) begin
				present[new_addr] <= 1'b1;
				timer[new_addr]   <= TXQ_TMR_W'(TXQ_RETX_TICKS);  // first send is due at once
				tries[new_addr]   <= '0;
			end
			if (upd) begin
				present[upd_addr] <= upd_present;
				timer[upd_addr]   <= upd_timer;
				tries[upd_addr]   <= upd_tries;
				q_present         <= upd_present;  // write through
				q_timer           <= upd_timer;
				q_tries           <= upd_tries;
			end else begin
				q_present <= present[upd_addr];
				q_timer   <= timer[upd_addr];
				q_tries   <= tries[upd_addr];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			seq_a[new_addr]  <= new_seq;
			ack_a[new_addr]  <= new_exp_ack;
			len_a[new_addr]  <= new_len;
			csum_a[new_addr] <= new_csum;
		end
		q_seq     <= seq_a[upd_addr];
		q_exp_ack <= ack_a[upd_addr];
		q_len     <= len_a[upd_addr];
		q_csum    <= csum_a[upd_addr];
	end

endmodule

// File: source/tcp_retx_scanner.sv
// -------------------------------------------------
// tcp tx retransmit scanner
// walks descriptors, sends, frees acked entries,
// resends on timeout and flushes the table
// -------------------------------------------------
`timescale 1ns/1ps

module tcp_retx_scanner import tcp_txq_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  sess_rst,
	input  logic                  flush_queue,
	input  logic                  tx_busy,
	input  logic                  tx_done,
	input  logic [31:0]           rem_ack,
	input  logic                  load_pend,
	output logic                  upd,
	output logic [TXQ_PKT_AW-1:0] upd_addr,
	output logic                  upd_present,
	output logic [TXQ_TMR_W-1:0]  upd_timer,
	output logic [TXQ_TRY_W-1:0]  upd_tries,
	output logic [TXQ_PKT_AW:0]   free_ptr,
	output logic                  val,
	output logic [31:0]           seq,
	output logic [15:0]           len,
	output logic [31:0]           payload_checksum,
	output logic                  force_fin,
	output logic                  queue_flushed,
	input  logic                  q_present,
	input  logic [31:0]           q_seq,
	input  logic [31:0]           q_exp_ack,
	input  logic [15:0]           q_len,
	input  logic [31:0]           q_csum,
	input  logic [TXQ_TMR_W-1:0]  q_timer,
	input  logic [TXQ_TRY_W-1:0]  q_tries
);

	logic [2:0]          state;
	logic [31:0]         ack_diff;   // rem_ack - exp_ack
	logic                free_f;     // entry acked
	logic                send_f;     // timer ran out
	logic [TXQ_PKT_AW:0] flush_cnt;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state         <= TXQ_S_SCAN;
			upd           <= 1'b0;
			upd_addr      <= '0;
			upd_present   <= 1'b0;
			upd_timer     <= '0;
			upd_tries     <= '0;
			free_ptr      <= '0;
			val           <= 1'b0;
			force_fin     <= 1'b0;
			queue_flushed <= 1'b0;
			free_f        <= 1'b0;
			send_f        <= 1'b0;
			flush_cnt     <= '0;
		end else if (sess_rst) begin
			state     <= TXQ_S_FLUSH;  // a new session voids the old segments
			flush_cnt <= '0;
			upd       <= 1'b0;
			val       <= 1'b0;
		end else begin
			upd           <= 1'b0;
			queue_flushed <= 1'b0;
			case (state)
				TXQ_S_SCAN: begin  // q holds entry upd_addr here
					if (flush_queue) begin
						state     <= TXQ_S_FLUSH;
						flush_cnt <= '0;
					end else if (q_present && !load_pend) state <= TXQ_S_READ;
					else state <= TXQ_S_NEXT;
				end
				TXQ_S_READ: begin
					free_f <= !ack_diff[31];  // ack at or past exp_ack
					send_f <= (q_timer == TXQ_TMR_W'(TXQ_RETX_TICKS));
					state  <= TXQ_S_CHECK;
				end
				TXQ_S_CHECK: begin
					if (!tx_busy) begin  // hold until transmitter is free
						upd <= 1'b1;
						if (free_f) begin
							upd_present <= 1'b0;
							upd_timer   <= '0;
							upd_tries   <= '0;
							free_ptr    <= free_ptr + 1'b1;
							state       <= TXQ_S_NEXT;
						end else if (send_f) begin
							upd_present <= 1'b1;
							upd_timer   <= '0;
							upd_tries   <= (q_tries == '1) ? q_tries : q_tries + 1'b1;
							val         <= 1'b1;
							if (q_tries == TXQ_TRY_W'(TXQ_MAX_TRIES)) force_fin <= 1'b1;
							state       <= TXQ_S_RETRANS;
						end else begin
							upd_present <= 1'b1;
							upd_timer   <= q_timer + 1'b1;  // one more visit
							upd_tries   <= q_tries;
							state       <= TXQ_S_NEXT;
						end
					end
				end
				TXQ_S_NEXT: begin
					upd_addr <= upd_addr + 1'b1;
					state    <= TXQ_S_WAIT;
				end
				TXQ_S_WAIT: state <= TXQ_S_SCAN;  // table read latency
				TXQ_S_RETRANS: begin
					if (tx_done) begin
						val   <= 1'b0;
						state <= TXQ_S_NEXT;
					end
				end
				TXQ_S_FLUSH: begin
					val <= 1'b0;
					if (flush_cnt[TXQ_PKT_AW]) begin  // all entries cleared
						queue_flushed <= 1'b1;
						upd_addr      <= '0;
						free_ptr      <= '0;
						force_fin     <= 1'b0;
						state         <= TXQ_S_WAIT;
					end else begin
						upd         <= 1'b1;
						upd_addr    <= flush_cnt[TXQ_PKT_AW-1:0];
						upd_present <= 1'b0;
						upd_timer   <= '0;
						upd_tries   <= '0;
						flush_cnt   <= flush_cnt + 1'b1;
					end
				end
				default: state <= TXQ_S_SCAN;
			endcase
		end
	end

	// fields held for the transmitter while val is high
	always_ff @(posedge clk) begin
		if (state == TXQ_S_SCAN) ack_diff <= rem_ack - q_exp_ack;
		if (state == TXQ_S_CHECK && !tx_busy && !free_f && send_f) begin
			seq              <= q_seq;
			len              <= q_len;
			payload_checksum <= q_csum;
		end
	end

	// transmitter still idle in the first cycle of val
	a_val_not_busy: assert property (@(posedge clk) disable iff (rst)
		$rose(val) |-> !tx_busy);

endmodule

// File: source/tcp_segmenter.sv
// -------------------------------------------------
// tcp tx segmenter
// splits the byte stream on mtu or idle, sums the
// payload and emits one descriptor per segment
// -------------------------------------------------
`timescale 1ns/1ps

module tcp_segmenter import tcp_txq_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   connected,
	input  logic [31:0]            isn,
	input  logic [7:0]             in_d,
	input  logic                   in_v,
	input  logic                   flush_queue,
	input  logic [TXQ_DATA_AW-1:0] space_left,
	input  logic [TXQ_PKT_AW:0]    free_ptr,
	input  logic [31:0]            rem_ack,
	input  logic                   val,
	output logic                   cts,
	output logic                   sess_rst,
	output logic                   load,
	output logic                   load_pend,
	output logic [TXQ_PKT_AW-1:0]  new_addr,
	output logic [31:0]            new_seq,
	output logic [31:0]            new_exp_ack,
	output logic [15:0]            new_len,
	output logic [31:0]            new_csum
);

	logic                  connected_q;
	logic [TXQ_CNT_W-1:0]  cnt;        // bytes in the open segment
	logic [TXQ_CNT_W-1:0]  cnt_n;
	logic [TXQ_IDLE_W-1:0] idle;       // cycles since last byte
	logic [31:0]           cur_seq;    // seq of next byte
	logic [31:0]           cur_seq_n;
	logic [31:0]           csum;
	logic [31:0]           csum_n;
	logic [7:0]            hi;         // high byte of a half word
	logic [7:0]            hi_n;
	logic                  odd;
	logic                  odd_n;
	logic                  acc;
	logic                  close;
	logic [TXQ_PKT_AW:0]   new_ptr;
	logic [TXQ_PKT_AW:0]   used;       // live descriptors
	logic [31:0]           rem_ack_q;
	logic                  upd_cts;

	assign acc       = in_v && !flush_queue;
	assign close     = (acc && cnt == TXQ_MTU - 1) ||
	                   (!acc && !flush_queue && cnt != '0 && idle == TXQ_WAIT_TICKS - 1);
	assign load_pend = close || load;  // descriptor about to be written
	assign new_addr  = new_ptr[TXQ_PKT_AW-1:0];
	assign used      = new_ptr - free_ptr;

	// state after taking this cycle's byte
	always_comb begin
		cnt_n     = cnt + TXQ_CNT_W'(acc);
		cur_seq_n = cur_seq + 32'(acc);
		csum_n    = csum;
		hi_n      = hi;
		odd_n     = odd;
		if (acc) begin
			odd_n = !odd;
			if (odd) csum_n = csum + {16'h0, hi, in_d};  // big endian word
			else hi_n = in_d;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			connected_q <= 1'b0;
			sess_rst    <= 1'b1;
		end else begin
			connected_q <= connected;
			sess_rst    <= (connected != connected_q);  // any edge restarts the session
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt     <= '0;
			idle    <= '0;
			cur_seq <= '0;
			csum    <= '0;
			odd     <= 1'b0;
			load    <= 1'b0;
			new_ptr <= '0;
		end else if (sess_rst) begin
			cnt     <= '0;
			idle    <= '0;
			cur_seq <= isn;
			csum    <= '0;
			odd     <= 1'b0;
			load    <= 1'b0;
			new_ptr <= '0;
		end else begin
			load    <= close;
			cur_seq <= cur_seq_n;
			if (flush_queue) new_ptr <= '0;  // scanner restarts at entry 0
			else if (load) new_ptr <= new_ptr + 1'b1;
			if (flush_queue || close) begin  // drop or hand off the open segment
				cnt  <= '0;
				csum <= '0;
				odd  <= 1'b0;
			end else begin
				cnt  <= cnt_n;
				csum <= csum_n;
				odd  <= odd_n;
			end
			if (acc) idle <= '0;
			else if (idle != TXQ_WAIT_TICKS - 1) idle <= idle + 1'b1;  // saturate
		end
	end

	always_ff @(posedge clk) begin
		hi <= hi_n;
		if (close) begin
			new_seq     <= cur_seq_n - 32'(cnt_n);  // first byte of segment
			new_exp_ack <= cur_seq_n;
			new_len     <= 16'(cnt_n);
			// odd tail padded with a zero low byte
			new_csum    <= odd_n ? csum_n + {16'h0, hi_n, 8'h00} : csum_n;
		end
	end

	// cts follows one cycle behind its trigger so space_left has settled
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rem_ack_q <= '0;
			upd_cts   <= 1'b0;
			cts       <= 1'b0;
		end else begin
			rem_ack_q <= rem_ack;
			upd_cts   <= load || sess_rst || (rem_ack != rem_ack_q) || (val && !in_v);
			if (upd_cts) cts <= connected && !used[TXQ_PKT_AW] && (space_left >= TXQ_MTU);
		end
	end

	a_load_single: assert property (@(posedge clk) disable iff (rst)
		load |=> !load);

endmodule

// File: source/tcp_tx_queue.sv
// -------------------------------------------------
// tcp transmit queue top
// segmenter, byte buffer, descriptor table, scanner
// -------------------------------------------------
`timescale 1ns/1ps

module tcp_tx_queue import tcp_txq_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [7:0]             in_d,              // user stream
	input  logic                   in_v,
	output logic                   cts,
	output logic                   val,               // transmitter side
	output logic [31:0]            seq,
	output logic [15:0]            len,
	output logic [31:0]            payload_checksum,
	input  logic [TXQ_DATA_AW-1:0] addr,
	input  logic                   req,
	output logic [7:0]             data,
	input  logic                   tx_busy,
	input  logic                   tx_done,
	input  logic                   connected,         // connection side
	input  logic [31:0]            isn,
	input  logic [31:0]            rem_ack,
	input  logic                   flush_queue,
	output logic                   force_fin,
	output logic                   queue_flushed
);

	logic                   sess_rst;
	logic [TXQ_DATA_AW-1:0] space_left;
	logic                   load;
	logic                   load_pend;
	logic [TXQ_PKT_AW-1:0]  new_addr;
	logic [31:0]            new_seq;
	logic [31:0]            new_exp_ack;
	logic [15:0]            new_len;
	logic [31:0]            new_csum;
	logic                   upd;
	logic [TXQ_PKT_AW-1:0]  upd_addr;
	logic                   upd_present;
	logic [TXQ_TMR_W-1:0]   upd_timer;
	logic [TXQ_TRY_W-1:0]   upd_tries;
	logic [TXQ_PKT_AW:0]    free_ptr;
	logic                   q_present;
	logic [31:0]            q_seq;
	logic [31:0]            q_exp_ack;
	logic [15:0]            q_len;
	logic [31:0]            q_csum;
	logic [TXQ_TMR_W-1:0]   q_timer;
	logic [TXQ_TRY_W-1:0]   q_tries;

	tcp_byte_buffer u_buf (
		.clk        (clk),
		.rst        (rst),
		.sess_rst   (sess_rst),
		.w_v        (in_v),
		.w_d        (in_d),
		.init_addr  (isn[TXQ_DATA_AW-1:0]),
		.rd_addr    (addr),
		.r_v        (req),
		.r_q        (data),
		.rem_ack    (rem_ack),
		.space_left (space_left)
	);

	tcp_segmenter u_seg (
		.clk         (clk),
		.rst         (rst),
		.connected   (connected),
		.isn         (isn),
		.in_d        (in_d),
		.in_v        (in_v),
		.flush_queue (flush_queue),
		.space_left  (space_left),
		.free_ptr    (free_ptr),
		.rem_ack     (rem_ack),
		.val         (val),
		.cts         (cts),
		.sess_rst    (sess_rst),
		.load        (load),
		.load_pend   (load_pend),
		.new_addr    (new_addr),
		.new_seq     (new_seq),
		.new_exp_ack (new_exp_ack),
		.new_len     (new_len),
		.new_csum    (new_csum)
	);

	tcp_pkt_table u_tbl (
		.clk         (clk),
		.rst         (rst),
		.load        (load),
		.new_addr    (new_addr),
		.new_seq     (new_seq),
		.new_exp_ack (new_exp_ack),
		.new_len     (new_len),
		.new_csum    (new_csum),
		.upd         (upd),
		.upd_addr    (upd_addr),
		.upd_present (upd_present),
		.upd_timer   (upd_timer),
		.upd_tries   (upd_tries),
		.q_present   (q_present),
		.q_seq       (q_seq),
		.q_exp_ack   (q_exp_ack),
		.q_len       (q_len),
		.q_csum      (q_csum),
		.q_timer     (q_timer),
		.q_tries     (q_tries)
	);

	tcp_retx_scanner u_scan (
		.clk              (clk),
		.rst              (rst),
		.sess_rst         (sess_rst),
		.flush_queue      (flush_queue),
		.tx_busy          (tx_busy),
		.tx_done          (tx_done),
		.rem_ack          (rem_ack),
		.load_pend        (load_pend),
		.upd              (upd),
		.upd_addr         (upd_addr),
		.upd_present      (upd_present),
		.upd_timer        (upd_timer),
		.upd_tries        (upd_tries),
		.free_ptr         (free_ptr),
		.val              (val),
		.seq              (seq),
		.len              (len),
		.payload_checksum (payload_checksum),
		.force_fin        (force_fin),
		.queue_flushed    (queue_flushed),
		.q_present        (q_present),
		.q_seq            (q_seq),
		.q_exp_ack        (q_exp_ack),
		.q_len            (q_len),
		.q_csum           (q_csum),
		.q_timer          (q_timer),
		.q_tries          (q_tries)
	);

endmodule

// File: source/tcp_txq_pkg.sv
// -------------------------------------------------
// tcp tx queue package
// sizes, timers, limits and scanner state codes
// -------------------------------------------------
package tcp_txq_pkg;

	localparam int TXQ_MTU        = 32;  // max payload bytes per segment
	localparam int TXQ_WAIT_TICKS = 20;  // idle cycles before a partial segment closes
	localparam int TXQ_RETX_TICKS = 16;  // scanner visits between resends
	localparam int TXQ_MAX_TRIES  = 3;   // resends allowed before force_fin
	localparam int TXQ_DATA_AW    = 10;  // 1024 byte payload ring
	localparam int TXQ_PKT_AW     = 3;   // 8 descriptors

	// derived widths
	localparam int TXQ_CNT_W  = $clog2(TXQ_MTU + 1);
	localparam int TXQ_IDLE_W = $clog2(TXQ_WAIT_TICKS);
	localparam int TXQ_TMR_W  = $clog2(TXQ_RETX_TICKS + 1);
	localparam int TXQ_TRY_W  = $clog2(TXQ_MAX_TRIES + 2);  // room to pass the limit

	// scanner FSM encoding
	localparam logic [2:0] TXQ_S_SCAN    = 3'd0;
	localparam logic [2:0] TXQ_S_READ    = 3'd1;
	localparam logic [2:0] TXQ_S_CHECK   = 3'd2;
	localparam logic [2:0] TXQ_S_NEXT    = 3'd3;
	localparam logic [2:0] TXQ_S_WAIT    = 3'd4;
	localparam logic [2:0] TXQ_S_RETRANS = 3'd5;
	localparam logic [2:0] TXQ_S_FLUSH   = 3'd6;

endpackage

// File: verification/tcp_tx_queue_tb.sv
// -------------------------------------------------
// tcp tx queue testbench
// directed tests checked against a byte stream model
// -------------------------------------------------
`timescale 1ns/1ps

module tcp_tx_queue_tb import tcp_txq_pkg::*; ();

	localparam int          CLK_NS      = 8;
	localparam logic [31:0] ISN         = 32'h7000_0100;
	localparam int          SCAN_ROUND  = 5 * (2**TXQ_PKT_AW);  // worst case walk of the table
	localparam int          SEND_WAIT   = TXQ_WAIT_TICKS + 4 * SCAN_ROUND;
	localparam int          RETX_WAIT   = (TXQ_RETX_TICKS + 2) * SCAN_ROUND;
	localparam int          STALL_LIMIT = 64;  // cycles of cts low tolerated per burst
	localparam int          TEST_CYCLES = (5 * TXQ_MTU + 22) + 6 * STALL_LIMIT +
	                                      6 * SEND_WAIT + (TXQ_MAX_TRIES + 4) * RETX_WAIT;
	localparam int          WATCHDOG_CYCLES = TEST_CYCLES + 1000;

	logic                   clk;
	logic                   rst;
	logic [7:0]             in_d;
	logic                   in_v;
	logic                   cts;
	logic                   val;
	logic [31:0]            seq;
	logic [15:0]            len;
	logic [31:0]            payload_checksum;
	logic [TXQ_DATA_AW-1:0] addr;
	logic                   req;
	logic [7:0]             data;
	logic                   tx_busy;
	logic                   tx_done;
	logic                   connected;
	logic [31:0]            isn;
	logic [31:0]            rem_ack;
	logic                   flush_queue;
	logic                   force_fin;
	logic                   queue_flushed;

	logic [7:0]  stream [$];    // every byte given to the DUT, index = seq - isn
	logic [31:0] cap_seq [$];   // sends taken by the transmitter model
	logic [15:0] cap_len [$];
	logic [31:0] cap_csum [$];
	logic        cap_fin [$];
	logic        tx_auto;       // transmitter model answers val with tx_done
	int          n_checks;
	int          n_errors;
	int          test_err0;
	string       cur_test;

	initial clk = 1'b0;
	always #(CLK_NS / 2) clk = ~clk;

	tcp_tx_queue u_dut (
		.clk              (clk),
		.rst              (rst),
		.in_d             (in_d),
		.in_v             (in_v),
		.cts              (cts),
		.val              (val),
		.seq              (seq),
		.len              (len),
		.payload_checksum (payload_checksum),
		.addr             (addr),
		.req              (req),
		.data             (data),
		.tx_busy          (tx_busy),
		.tx_done          (tx_done),
		.connected        (connected),
		.isn              (isn),
		.rem_ack          (rem_ack),
		.flush_queue      (flush_queue),
		.force_fin        (force_fin),
		.queue_flushed    (queue_flushed)
	);

	task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_len(input string what, input logic [15:0] exp, input logic [15:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s %s: expected %0d actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s %s: expected %b actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic report_problem(input string msg);
		n_errors++;
		$display("ERROR %s: %s", cur_test, msg);
	endtask

	// sum of big endian half words, odd tail padded with a zero low byte
	function automatic logic [31:0] model_csum(input int first, input int n);
		logic [31:0] sum;
		logic [7:0]  lo;
		sum = '0;
		for (int i = 0; i < n; i += 2) begin
			lo  = (i + 1 < n) ? stream[first + i + 1] : 8'h00;
			sum = sum + {16'h0, stream[first + i], lo};
		end
		return sum;
	endfunction

	// one clock, outputs sampled on the falling edge
	task automatic advance();
		@(negedge clk);
		if (tx_auto && val && !tx_done) begin
			cap_seq.push_back(seq);
			cap_len.push_back(len);
			cap_csum.push_back(payload_checksum);
			cap_fin.push_back(force_fin);
			tx_done = 1'b1;  // segment is out
		end else begin
			tx_done = 1'b0;
		end
	endtask

	task automatic send_bytes(input int n);
		int sent;
		int guard;
		sent  = 0;
		guard = 0;
		while (sent < n && guard < n + STALL_LIMIT) begin
			advance();
			guard++;
			if (cts) begin
				in_d = 8'($urandom());
				in_v = 1'b1;
				stream.push_back(in_d);
				sent++;
			end else begin
				in_v = 1'b0;  // hold off while cts is low
			end
		end
		advance();  // last byte taken on this edge
		in_v = 1'b0;
		if (sent < n) report_problem($sformatf("cts stayed low, %0d of %0d bytes sent", sent, n));
	endtask

	task automatic wait_sends(input int n, input int limit);
		int waited;
		waited = 0;
		while (cap_seq.size() < n && waited < limit) begin
			advance();
			waited++;
		end
		if (cap_seq.size() < n)
			report_problem($sformatf("only %0d of %0d sends within %0d cycles",
				cap_seq.size(), n, limit));
	endtask

	task automatic compare_segment(input int k, input int first, input int n);
		if (k < cap_seq.size()) begin
			check_word("seq", isn + 32'(first), cap_seq[k]);
			check_len("len", 16'(n), cap_len[k]);
			check_word("checksum", model_csum(first, n), cap_csum[k]);
		end
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_err0 = n_errors;
		cap_seq.delete();
		cap_len.delete();
		cap_csum.delete();
		cap_fin.delete();
	endtask

	task automatic finish_test();
		if (n_errors == test_err0) $display("test %s: ok", cur_test);
		else $display("test %s: %0d errors", cur_test, n_errors - test_err0);
	endtask

	task automatic mtu_split();
		int first;
		start_test("mtu_split");
		first   = stream.size();
		tx_auto = 1'b1;
		send_bytes(2 * TXQ_MTU + 5);
		wait_sends(3, 3 * SEND_WAIT);
		compare_segment(0, first, TXQ_MTU);
		compare_segment(1, first + TXQ_MTU, TXQ_MTU);
		compare_segment(2, first + 2 * TXQ_MTU, 5);  // tail closed by idle
		finish_test();
	endtask

	task automatic odd_idle_segment();
		int first;
		start_test("odd_idle_segment");
		first   = stream.size();
		tx_auto = 1'b1;
		send_bytes(3);
		wait_sends(1, SEND_WAIT);
		compare_segment(0, first, 3);
		finish_test();
	endtask

	task automatic data_readback();
		int          first;
		int          waited;
		logic [31:0] s;
		start_test("data_readback");
		first   = stream.size();
		tx_auto = 1'b0;  // hold val while reading
		send_bytes(10);
		waited = 0;
		while (!val && waited < SEND_WAIT) begin
			advance();
			waited++;
		end
		if (!val) begin
			report_problem("val never rose for the new segment");
		end else begin
			s = seq;
			check_word("seq", isn + 32'(first), s);
			check_len("len", 16'd10, len);
			for (int i = 0; i < 10; i++) begin
				addr = TXQ_DATA_AW'(s + 32'(i));
				req  = 1'b1;
				advance();  // data one cycle after req
				check_byte($sformatf("data[%0d]", i), stream[first + i], data);
			end
			req     = 1'b0;
			tx_done = 1'b1;
			advance();
			check_flag("val after tx_done", 1'b0, val);
		end
		finish_test();
	endtask

	task automatic ack_release();
		start_test("ack_release");
		tx_auto = 1'b1;
		rem_ack = isn + 32'(stream.size());  // covers exp_ack of every segment
		repeat (RETX_WAIT) advance();
		if (cap_seq.size() != 0)
			report_problem($sformatf("%0d sends after every segment was acked", cap_seq.size()));
		check_flag("cts", 1'b1, cts);
		finish_test();
	endtask

	task automatic retransmit_fin();
		int first;
		start_test("retransmit_fin");
		first   = stream.size();
		tx_auto = 1'b1;
		send_bytes(4);
		wait_sends(TXQ_MAX_TRIES + 1, (TXQ_MAX_TRIES + 1) * RETX_WAIT);
		// k earlier sends means k tries, fin once tries reach the limit
		for (int k = 0; k < cap_seq.size(); k++) begin
			check_word($sformatf("seq of send %0d", k), isn + 32'(first), cap_seq[k]);
			check_flag($sformatf("force_fin at send %0d", k), 1'(k >= TXQ_MAX_TRIES), cap_fin[k]);
		end
		check_flag("force_fin held", 1'b1, force_fin);
		finish_test();
	endtask

	task automatic flush_queue_clear();
		int pulses;
		int waited;
		start_test("flush_queue_clear");
		tx_auto = 1'b1;
		send_bytes(2 * TXQ_MTU);
		repeat (4) advance();  // both descriptors loaded
		flush_queue = 1'b1;
		pulses      = 0;
		waited      = 0;
		while (pulses == 0 && waited < RETX_WAIT) begin
			advance();
			waited++;
			if (queue_flushed) pulses++;
		end
		flush_queue = 1'b0;
		if (pulses == 0) report_problem("no queue_flushed pulse after flush_queue");
		cap_seq.delete();
		repeat (RETX_WAIT) begin
			advance();
			if (queue_flushed) pulses++;
		end
		if (cap_seq.size() != 0) report_problem("val rose after the queue was flushed");
		if (pulses > 1) report_problem("queue_flushed pulsed more than once");
		finish_test();
	endtask

	initial begin
		void'($urandom(32'h76d5));
		rst         = 1'b1;
		in_d        = 8'h00;
		in_v        = 1'b0;
		addr        = '0;
		req         = 1'b0;
		tx_busy     = 1'b0;
		tx_done     = 1'b0;
		connected   = 1'b1;
		isn         = ISN;
		rem_ack     = ISN;  // nothing acked yet
		flush_queue = 1'b0;
		tx_auto     = 1'b0;
		n_checks    = 0;
		n_errors    = 0;
		cur_test    = "reset";
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (20) advance();  // session reset and initial table flush
		mtu_split();
		odd_idle_segment();
		data_readback();
		ack_release();
		retransmit_fin();
		flush_queue_clear();
		$display("6 tests, %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// bound on the whole run
	initial begin
		#(WATCHDOG_CYCLES * CLK_NS);
		$display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test);
		$display("Checks failed");
		$finish;
	end

endmodule
